/* display_config.svh */
`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

////////////////////////////////////////////////////////////
// Video timing for the small simulation mode
////////////////////////////////////////////////////////////

// Horizontal timing in pixel clocks
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 4
`define H_BACK 2

// Vertical timing in lines
`define V_ACTIVE 12
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1

////////////////////////////////////////////////////////////
// Frame buffer geometry
////////////////////////////////////////////////////////////

`define FB_WIDTH 8
`define FB_HEIGHT 6
`define FB_ADDR_WIDTH 6

// Each buffer pixel covers a 2x2 block on screen
`define SCALE_SHIFT 1

`endif

/* display_pkg.sv */
`default_nettype none

`include "display_config.svh"

package display_pkg;

    localparam int COLOR_WIDTH = 4;
    localparam int ADDR_WIDTH = `FB_ADDR_WIDTH;
    localparam int FB_DEPTH = `FB_WIDTH * `FB_HEIGHT;

    // Coordinate widths inside the buffer
    localparam int FB_X_WIDTH = $clog2(`FB_WIDTH);
    localparam int FB_Y_WIDTH = $clog2(`FB_HEIGHT);

    // One pixel, red in the top bits
    typedef struct packed {
        logic [COLOR_WIDTH-1:0] red;
        logic [COLOR_WIDTH-1:0] green;
        logic [COLOR_WIDTH-1:0] blue;
    } rgb444_t;

    // Buffer write request
    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        rgb444_t               data;
    } fb_write_t;

    // Buffer read request, data follows one clock later
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } fb_read_t;

    // Registered VGA pins, syncs active low
    typedef struct packed {
        logic    hsync;
        logic    vsync;
        rgb444_t rgb;
    } vga_out_t;

endpackage

`default_nettype wire

/* frame_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module frame_buffer (
    input  logic                   clk_display,
    input  display_pkg::fb_write_t wr,
    input  display_pkg::fb_read_t  rd,
    output display_pkg::rgb444_t   rd_data
);
    import display_pkg::*;

    // One frame, row after row
    rgb444_t mem [0:FB_DEPTH-1];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // Registered read, data valid the clock after the address
    always_ff @(posedge clk_display) begin
        rd_data <= mem[rd.addr];
    end

    // Address space is 64 entries but only 48 hold pixels
    write_in_range: assert property (
        @(posedge clk_display)
        wr.en |-> (wr.addr < ADDR_WIDTH'(FB_DEPTH))
    ) else $error("frame_buffer write outside the frame at address %0d", wr.addr);

    // Display side is gated to the active window, so reads stay inside too
    read_in_range: assert property (
        @(posedge clk_display)
        rd.addr < ADDR_WIDTH'(FB_DEPTH)
    ) else $error("frame_buffer read outside the frame at address %0d", rd.addr);

endmodule

`default_nettype wire

/* pattern_drawer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "display_config.svh"

module pattern_drawer (
    input  logic                   clk_display,
    input  logic                   rstn_display,
    input  logic                   draw_ack,
    output display_pkg::fb_write_t draw_wr,
    output logic                   frame_done
);
    import display_pkg::*;

    localparam logic [FB_X_WIDTH-1:0] X_LAST = FB_X_WIDTH'(`FB_WIDTH - 1);
    localparam logic [FB_Y_WIDTH-1:0] Y_LAST = FB_Y_WIDTH'(`FB_HEIGHT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DRAW,
        ST_DONE
    } state_t;

    state_t                 state;
    logic [FB_X_WIDTH-1:0]  x;
    logic [FB_Y_WIDTH-1:0]  y;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [COLOR_WIDTH-1:0] frame_count;
    logic                   last_pixel;

    assign last_pixel = (x == X_LAST) && (y == Y_LAST);

    ////////////////////////////////////////////////////////////
    // Drawing FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state       <= ST_IDLE;
            x           <= '0;
            y           <= '0;
            addr        <= '0;
            frame_count <= '0;
            frame_done  <= 1'b0;
            draw_wr     <= '0;
        end else begin
            draw_wr.en <= 1'b0;
            case (state)
                // Start of a frame, counters back to the top left
                ST_IDLE: begin
                    x     <= '0;
                    y     <= '0;
                    addr  <= '0;
                    state <= ST_DRAW;
                end
                // One pixel per clock, row by row
                ST_DRAW: begin
                    draw_wr.en         <= 1'b1;
                    draw_wr.addr       <= addr;
                    draw_wr.data.red   <= frame_count;
                    draw_wr.data.green <= COLOR_WIDTH'(x);
                    draw_wr.data.blue  <= COLOR_WIDTH'(y);
                    addr               <= addr + 1'b1;
                    if (x == X_LAST) begin
                        x <= '0;
                        y <= y + 1'b1;
                    end else begin
                        x <= x + 1'b1;
                    end
                    if (last_pixel) begin
                        state <= ST_DONE;
                    end
                end
                // Last write has gone out, hold until the swap
                ST_DONE: begin
                    frame_done <= 1'b1;
                    if (draw_ack) begin
                        frame_done  <= 1'b0;
                        frame_count <= frame_count + 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Buffer may be on display once frame_done is up
    no_write_when_done: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        frame_done |-> !draw_wr.en
    ) else $error("pattern_drawer wrote while frame_done was high");

endmodule

`default_nettype wire

/* vga_timing.sv */
`default_nettype none
`timescale 1ns/1ps

`include "display_config.svh"

module vga_timing (
    input  logic                   clk_display,
    input  logic                   rstn_display,
    output display_pkg::fb_read_t  disp_rd,
    input  display_pkg::rgb444_t   disp_pixel,
    output display_pkg::vga_out_t  vga
);
    import display_pkg::*;

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int H_CNT_WIDTH = $clog2(H_TOTAL);
    localparam int V_CNT_WIDTH = $clog2(V_TOTAL);

    logic [H_CNT_WIDTH-1:0] h_count;
    logic [V_CNT_WIDTH-1:0] v_count;
    logic                   hsync_n;
    logic                   vsync_n;
    logic                   active;
    logic [FB_X_WIDTH-1:0]  fb_x;
    logic [FB_Y_WIDTH-1:0]  fb_y;
    logic                   hsync_d;
    logic                   vsync_d;
    logic                   active_d;

    ////////////////////////////////////////////////////////////
    // Scan counters
    ////////////////////////////////////////////////////////////

    // Line layout is active, front porch, sync, back porch
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_CNT_WIDTH'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == V_CNT_WIDTH'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign hsync_n = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_START + `H_SYNC));
    assign vsync_n = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_START + `V_SYNC));
    assign active = (h_count < `H_ACTIVE) && (v_count < `V_ACTIVE);

    ////////////////////////////////////////////////////////////
    // Buffer addressing
    ////////////////////////////////////////////////////////////

    assign fb_x = FB_X_WIDTH'(h_count >> `SCALE_SHIFT);
    assign fb_y = FB_Y_WIDTH'(v_count >> `SCALE_SHIFT);

    // Address held at zero in blanking
    always_comb begin
        disp_rd.addr = '0;
        if (active) begin
            disp_rd.addr = ADDR_WIDTH'(fb_y * `FB_WIDTH + fb_x);
        end
    end

    ////////////////////////////////////////////////////////////
    // Output alignment
    ////////////////////////////////////////////////////////////

    // Delay stage matches the RAM read latency, then the pin register
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            active_d <= 1'b0;
            vga      <= '{hsync: 1'b1, vsync: 1'b1, rgb: '0};
        end else begin
            hsync_d   <= hsync_n;
            vsync_d   <= vsync_n;
            active_d  <= active;
            vga.hsync <= hsync_d;
            vga.vsync <= vsync_d;
            vga.rgb   <= active_d ? disp_pixel : '0;
        end
    end

endmodule

`default_nettype wire

/* buffer_swap_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module buffer_swap_ctrl (
    input  logic                   clk_display,
    input  logic                   rstn_display,
    input  logic                   vsync,
    input  logic                   frame_done,
    output logic                   draw_ack,
    input  display_pkg::fb_write_t draw_wr,
    input  display_pkg::fb_read_t  disp_rd,
    output display_pkg::rgb444_t   disp_pixel,
    output display_pkg::fb_write_t fb_a_wr,
    output display_pkg::fb_write_t fb_b_wr,
    output display_pkg::fb_read_t  fb_a_rd,
    output display_pkg::fb_read_t  fb_b_rd,
    input  display_pkg::rgb444_t   fb_a_data,
    input  display_pkg::rgb444_t   fb_b_data
);
    logic vsync_d;
    logic swap_req;
    logic buffer_select;
    logic rd_select;

    ////////////////////////////////////////////////////////////
    // Swap on the end of the vsync pulse
    ////////////////////////////////////////////////////////////

    // Sync idles high, so no edge is seen right after reset
    assign swap_req = vsync && !vsync_d && frame_done;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vsync_d       <= 1'b1;
            buffer_select <= 1'b0;
            draw_ack      <= 1'b0;
            rd_select     <= 1'b0;
        end else begin
            vsync_d   <= vsync;
            draw_ack  <= swap_req;
            rd_select <= buffer_select;
            if (swap_req) begin
                buffer_select <= !buffer_select;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Port routing
    ////////////////////////////////////////////////////////////

    // Select 0 shows A and draws into B
    always_comb begin
        fb_a_wr    = draw_wr;
        fb_b_wr    = draw_wr;
        fb_a_wr.en = draw_wr.en && buffer_select;
        fb_b_wr.en = draw_wr.en && !buffer_select;
        fb_a_rd    = '0;
        fb_b_rd    = '0;
        if (buffer_select) begin
            fb_b_rd = disp_rd;
        end else begin
            fb_a_rd = disp_rd;
        end
    end

    // Data returns a clock later, from the buffer that got the address
    assign disp_pixel = rd_select ? fb_b_data : fb_a_data;

    ack_only_when_done: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        draw_ack |-> frame_done
    ) else $error("draw_ack raised without a finished frame");

endmodule

`default_nettype wire

/* display_top.sv */
`default_nettype none
`timescale 1ns/1ps

module display_top (
    input  logic                              clk_display,
    input  logic                              rstn_display,
    output logic                              vga_hsync,
    output logic                              vga_vsync,
    output logic [display_pkg::COLOR_WIDTH-1:0] vga_red,
    output logic [display_pkg::COLOR_WIDTH-1:0] vga_green,
    output logic [display_pkg::COLOR_WIDTH-1:0] vga_blue
);
    import display_pkg::*;

    // Drawer side
    fb_write_t draw_wr;
    logic      frame_done;
    logic      draw_ack;

    // Display side
    fb_read_t  disp_rd;
    rgb444_t   disp_pixel;
    vga_out_t  vga;

    // Buffer ports
    fb_write_t fb_a_wr;
    fb_write_t fb_b_wr;
    fb_read_t  fb_a_rd;
    fb_read_t  fb_b_rd;
    rgb444_t   fb_a_data;
    rgb444_t   fb_b_data;

    ////////////////////////////////////////////////////////////
    // Drawing and swap
    ////////////////////////////////////////////////////////////

    pattern_drawer u_drawer (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .draw_ack     (draw_ack),
        .draw_wr      (draw_wr),
        .frame_done   (frame_done)
    );

    buffer_swap_ctrl u_swap (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .vsync        (vga.vsync),
        .frame_done   (frame_done),
        .draw_ack     (draw_ack),
        .draw_wr      (draw_wr),
        .disp_rd      (disp_rd),
        .disp_pixel   (disp_pixel),
        .fb_a_wr      (fb_a_wr),
        .fb_b_wr      (fb_b_wr),
        .fb_a_rd      (fb_a_rd),
        .fb_b_rd      (fb_b_rd),
        .fb_a_data    (fb_a_data),
        .fb_b_data    (fb_b_data)
    );

    ////////////////////////////////////////////////////////////
    // Frame buffers and scan-out
    ////////////////////////////////////////////////////////////

    frame_buffer u_fb_a (
        .clk_display (clk_display),
        .wr          (fb_a_wr),
        .rd          (fb_a_rd),
        .rd_data     (fb_a_data)
    );

    frame_buffer u_fb_b (
        .clk_display (clk_display),
        .wr          (fb_b_wr),
        .rd          (fb_b_rd),
        .rd_data     (fb_b_data)
    );

    vga_timing u_timing (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .disp_rd      (disp_rd),
        .disp_pixel   (disp_pixel),
        .vga          (vga)
    );

    // Pins
    assign vga_hsync = vga.hsync;
    assign vga_vsync = vga.vsync;
    assign vga_red   = vga.rgb.red;
    assign vga_green = vga.rgb.green;
    assign vga_blue  = vga.rgb.blue;

endmodule

`default_nettype wire

/* tb_display_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "display_config.svh"

module tb_display_top;
    import display_pkg::*;

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    // Clocks from the hsync falling edge to screen pixel 0
    localparam int PIXEL_OFFSET = `H_SYNC + `H_BACK;
    localparam int FRAMES = 18;
    localparam int TIMEOUT_CLOCKS = 2000;
    localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;

    logic                   clk_display;
    logic                   rstn_display;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic [COLOR_WIDTH-1:0] vga_red;
    logic [COLOR_WIDTH-1:0] vga_green;
    logic [COLOR_WIDTH-1:0] vga_blue;

    int   error_count = 0;
    int   timeout_count = 0;
    int   pixel_count = 0;
    int   cycle = 0;
    int   last_hs_fall_cycle = 0;
    int   vsync_rises = 0;
    logic wrap_seen = 1'b0;

    display_top u_dut (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

    initial begin
        clk_display = 1'b0;
        forever #5 clk_display = ~clk_display;
    end

    ////////////////////////////////////////////////////////////
    // Expected pixels
    ////////////////////////////////////////////////////////////

    // Red carries the frame index, green and blue the buffer coordinates
    function automatic rgb444_t expected_pixel(input int frame_idx, input int sx, input int sy);
        rgb444_t px;
        int      bx;
        int      by;
        bx = sx >> `SCALE_SHIFT;
        by = sy >> `SCALE_SHIFT;
        px.red   = 4'(frame_idx % 16);
        px.green = 4'(bx);
        px.blue  = 4'(by);
        return px;
    endfunction

    task automatic record_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic check_idle_outputs(input string phase);
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 ||
            {vga_red, vga_green, vga_blue} !== 12'h000) begin
            record_error($sformatf("%s: hsync %b vsync %b rgb %h instead of idle levels",
                phase, vga_hsync, vga_vsync, {vga_red, vga_green, vga_blue}));
        end
    endtask

    // Returns once the given number of vsync rising edges has been seen
    task automatic wait_vsync_rise(input int target, output logic timed_out);
        int waited;
        waited = 0;
        timed_out = 1'b0;
        while (vsync_rises < target && waited < TIMEOUT_CLOCKS && !timed_out) begin
            @(posedge clk_display);
            waited++;
            if (cycle - last_hs_fall_cycle > TIMEOUT_CLOCKS) begin
                $display("Timeout: vga_hsync stuck, no falling edge in %0d clocks",
                    TIMEOUT_CLOCKS);
                timed_out = 1'b1;
            end
        end
        if (!timed_out && vsync_rises < target) begin
            $display("Timeout: vga_vsync stuck, rising edge %0d not seen in %0d clocks",
                target, TIMEOUT_CLOCKS);
            timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Sync and pixel monitor
    ////////////////////////////////////////////////////////////

    // Outputs are registered on the rising edge, so sample on the falling one
    always @(negedge clk_display) begin : monitor
        logic    prev_hs;
        logic    prev_vs;
        logic    hs_fall_seen;
        logic    vs_fall_seen;
        logic    vs_rise_seen;
        int      hs_low_start;
        int      vs_low_start;
        int      last_vs_rise;
        int      h_pos;
        int      line_idx;
        int      x;
        int      frame_pixels;
        logic    frame_red_valid;
        logic    prev_red_valid;
        logic [3:0] frame_red;
        logic [3:0] prev_red;
        rgb444_t got;
        rgb444_t exp;
        if (!rstn_display) begin
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            hs_fall_seen = 1'b0;
            vs_fall_seen = 1'b0;
            vs_rise_seen = 1'b0;
            h_pos = -1;
            line_idx = -1;
            frame_pixels = 0;
            frame_red_valid = 1'b0;
            prev_red_valid = 1'b0;
        end else begin
            cycle++;
            got = {vga_red, vga_green, vga_blue};
            if (h_pos >= 0) begin
                h_pos++;
            end

            // Horizontal sync
            if (prev_hs && !vga_hsync) begin
                if (hs_fall_seen && cycle - last_hs_fall_cycle != H_TOTAL) begin
                    record_error($sformatf("hsync period %0d clocks, expected %0d",
                        cycle - last_hs_fall_cycle, H_TOTAL));
                end
                hs_fall_seen = 1'b1;
                last_hs_fall_cycle = cycle;
                hs_low_start = cycle;
                h_pos = 0;
                line_idx++;
            end
            if (!prev_hs && vga_hsync && hs_fall_seen && cycle - hs_low_start != `H_SYNC) begin
                record_error($sformatf("hsync low for %0d clocks, expected %0d",
                    cycle - hs_low_start, `H_SYNC));
            end

            // Vertical sync, lines counted in clocks
            if (prev_vs && !vga_vsync) begin
                vs_fall_seen = 1'b1;
                vs_low_start = cycle;
            end
            if (!prev_vs && vga_vsync) begin
                if (vs_fall_seen && cycle - vs_low_start != `V_SYNC * H_TOTAL) begin
                    record_error($sformatf("vsync low for %0d clocks, expected %0d",
                        cycle - vs_low_start, `V_SYNC * H_TOTAL));
                end
                if (vs_rise_seen && cycle - last_vs_rise != V_TOTAL * H_TOTAL) begin
                    record_error($sformatf("vsync period %0d clocks, expected %0d",
                        cycle - last_vs_rise, V_TOTAL * H_TOTAL));
                end
                // Close out the frame that just finished
                if (vsync_rises >= 1) begin
                    if (frame_pixels != FRAME_PIXELS) begin
                        record_error($sformatf("frame %0d showed %0d active pixels, expected %0d",
                            vsync_rises - 1, frame_pixels, FRAME_PIXELS));
                    end
                    if (frame_red_valid && prev_red_valid && frame_red != prev_red + 4'd1) begin
                        record_error($sformatf("frame index went from %0d to %0d",
                            prev_red, frame_red));
                    end
                    if (frame_red_valid && prev_red_valid && prev_red == 4'd15 &&
                        frame_red == 4'd0) begin
                        wrap_seen = 1'b1;
                    end
                    prev_red = frame_red;
                    prev_red_valid = frame_red_valid;
                end
                vs_rise_seen = 1'b1;
                last_vs_rise = cycle;
                vsync_rises++;
                line_idx = -1;
                frame_pixels = 0;
                frame_red_valid = 1'b0;
            end

            // Colour checks once the horizontal position is known
            if (h_pos >= 0) begin
                x = h_pos - PIXEL_OFFSET;
                if (vsync_rises >= 1 && x >= 0 && x < `H_ACTIVE &&
                    line_idx >= 0 && line_idx < `V_ACTIVE) begin
                    exp = expected_pixel(vsync_rises - 1, x, line_idx);
                    if (got !== exp) begin
                        record_error($sformatf("pixel (%0d,%0d) of frame %0d is %h, expected %h",
                            x, line_idx, vsync_rises - 1, got, exp));
                    end
                    if (!frame_red_valid) begin
                        frame_red = got.red;
                        frame_red_valid = 1'b1;
                    end else if (got.red !== frame_red) begin
                        record_error($sformatf("frame %0d mixes indices %0d and %0d",
                            vsync_rises - 1, frame_red, got.red));
                    end
                    frame_pixels++;
                    pixel_count++;
                end else if ((x < 0 || x >= `H_ACTIVE || vsync_rises >= 1) &&
                             got !== 12'h000) begin
                    record_error($sformatf("colour %h during blanking at line %0d x %0d",
                        got, line_idx, x));
                end
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        logic timed_out;
        int   target;
        timed_out = 1'b0;
        rstn_display = 1'b0;
        void'($urandom(32'h5a20));

        for (int i = 0; i < 5; i++) begin
            @(negedge clk_display);
            check_idle_outputs("during reset");
        end
        @(posedge clk_display);
        #1 rstn_display = 1'b1;
        @(posedge clk_display);
        @(negedge clk_display);
        check_idle_outputs("first clock after reset");

        // One extra rise closes the last displayed frame
        target = 1;
        while (target <= FRAMES + 1 && !timed_out) begin
            wait_vsync_rise(target, timed_out);
            target++;
        end

        if (timed_out) begin
            timeout_count++;
        end else if (!wrap_seen) begin
            record_error("red field never wrapped from 15 to 0");
        end

        $display("Summary: %0d errors, %0d timeouts, %0d frames, %0d pixels checked",
            error_count, timeout_count, vsync_rises - 1, pixel_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
display_pkg.sv
frame_buffer.sv
pattern_drawer.sv
vga_timing.sv
buffer_swap_ctrl.sv
display_top.sv
tb_display_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the display testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_display_top -o sim_display

./obj_dir/sim_display | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
